//--- mikie_board.f
+incdir+include
verilog/mikie_pkg.sv
verilog/mikie_clocks.sv
verilog/mikie_rom_loader.sv
verilog/mikie_vtimer.sv
verilog/mikie_colmix.sv
verilog/mikie_board.sv
verif/mikie_board_checker.sv
verif/mikie_board_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the board testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module mikie_board_tb \
    -f mikie_board.f -o sim_mikie_board

./obj_dir/sim_mikie_board > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q ">>> FAIL" "$LOG"; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q ">>> PASS" "$LOG"; then
    echo "simulation ended early"
    exit 1
fi
echo "simulation passed"

//--- verif/mikie_board_tb.sv
/*
 * Directed testbench for the board glue top level
 * Runs reset, download unscrambling, colour lookup and raster timing
 * tests, with expected values worked out from the memory map and timing.
 */
`timescale 1ns/10ps
`include "mikie_defines.svh"

module mikie_board_tb;

    localparam int CLK_NS     = 40;
    localparam int LINE_CLKS  = `MIKIE_HTOTAL * 8;
    localparam int FRAME_CLKS = LINE_CLKS * `MIKIE_VTOTAL;
    // Two frames, the download tests and some slack lines
    localparam int LIMIT_CLKS = 2 * FRAME_CLKS + 768 + 4 * 200 + 8 * LINE_CLKS;

    logic                     clk;
    logic                     reset;
    logic [`MIKIE_ADDR_W-1:0] ioctl_addr;
    logic [7:0]               ioctl_dout;
    logic                     ioctl_wr;
    logic [4:0]               pix_idx;
    logic [2:0]               pal_sel;
    mikie_pkg::dl_write_t     prog;
    logic                     pxl_cen;
    logic                     pxl2_cen;
    logic [`MIKIE_CNT_W-1:0]  hcnt;
    logic [`MIKIE_CNT_W-1:0]  vcnt;
    logic                     HS;
    logic                     VS;
    logic                     LHBL;
    logic                     LVBL;
    logic                     V16;
    logic [3:0]               red;
    logic [3:0]               green;
    logic [3:0]               blue;
    logic [31:0]              rng_state;
    logic [3:0]               prom_copy [0:767];

    mikie_board UUT (.*);

    bind mikie_board mikie_board_checker u_check (
        .clk, .reset, .pxl_cen, .pxl2_cen, .lhbl(LHBL), .lvbl(LVBL), .red, .green, .blue
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #(LIMIT_CLKS * CLK_NS);
        $display("timeout: the tests did not finish in the expected time");
        abort_run();
    end

    always @(negedge clk) begin
        if (UUT.u_check.failures != 0) begin
            $display("a concurrent assertion in the bound checker failed");
            abort_run();
        end
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Object ROM address order on the board
    function automatic logic [`MIKIE_ADDR_W-1:0] obj_unscramble(input logic [21:0] a);
        logic [`MIKIE_ADDR_W-1:0] o;
        o = a;
        o[15] = a[0];
        o[14] = a[15];
        o[0] = !a[14];
        o[2:1] = a[5:4] + 2'd1;
        o[6:3] = {a[6], a[3], a[2], a[1]};
        return o;
    endfunction

    task automatic abort_run();
        $display(">>> FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string test, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        assert (act == exp) else begin
            $display("error %s: %s expected 0x%0h, actual 0x%0h", test, what, exp, act);
            abort_run();
        end
    endtask

    task automatic write_and_check(input string test, input logic [21:0] addr,
                                   input logic [7:0] data, input logic [21:0] exp_addr,
                                   input logic [7:0] exp_data);
        @(posedge clk);
        ioctl_addr <= addr;
        ioctl_dout <= data;
        ioctl_wr   <= 1'b1;
        @(posedge clk);
        ioctl_wr   <= 1'b0;
        @(negedge clk);
        check_value(test, "prog.we", 1, prog.we);
        check_value(test, "prog.addr", exp_addr, prog.addr);
        check_value(test, "prog.data", exp_data, prog.data);
        @(negedge clk);
        check_value(test, "prog.we after write", 0, prog.we);
    endtask

    // Returns just after the next rising edge that carries pxl_cen
    task automatic wait_cen_edge();
        do @(negedge clk); while (!pxl_cen);
        @(posedge clk);
    endtask

    task automatic reset_and_enables();
        int i;
        int n2;
        int n1;
        n2 = 0;
        n1 = 0;
        @(negedge clk);
        check_value("reset", "prog.we", 0, prog.we);
        check_value("reset", "prom_we", 0, UUT.u_loader.prom_we);
        check_value("reset", "hcnt", 0, hcnt);
        check_value("reset", "vcnt", 0, vcnt);
        check_value("reset", "LHBL LVBL HS VS", 4'b1100, {LHBL, LVBL, HS, VS});
        check_value("reset", "rgb", 0, {red, green, blue});
        for (i = 1; i <= 4; i++) begin
            @(negedge clk);
            check_value("reset", "first pxl2_cen", (i == 4), pxl2_cen);
        end
        repeat (64) begin
            @(negedge clk);
            n2 += pxl2_cen;
            n1 += pxl_cen;
        end
        check_value("reset", "pxl2_cen pulses", 16, n2);
        check_value("reset", "pxl_cen pulses", 8, n1);
    endtask

    task automatic scroll_region();
        logic [31:0] r;
        logic [21:0] a;
        logic [7:0]  d;
        repeat (24) begin
            r = next_random();
            a = `MIKIE_SCR_START + 22'(r % (`MIKIE_OBJ_START - `MIKIE_SCR_START));
            d = r[31:24];
            write_and_check("scroll_region", a, d, a, {d[3:0], d[7:4]});
        end
        // Code space is left alone
        repeat (8) begin
            r = next_random();
            a = 22'(r % `MIKIE_SCR_START);
            d = r[31:24];
            write_and_check("code_region", a, d, a, d);
        end
    endtask

    task automatic object_region();
        logic [31:0] r;
        logic [21:0] a;
        repeat (24) begin
            r = next_random();
            a = `MIKIE_OBJ_START + 22'(r % (`MIKIE_PROM_START - `MIKIE_OBJ_START));
            write_and_check("object_region", a, r[31:24], obj_unscramble(a), r[31:24]);
        end
    endtask

    task automatic lookup_and_check(input logic [7:0] idx);
        do @(negedge clk); while (!(LHBL && LVBL && hcnt < `MIKIE_HACTIVE - 8));
        @(posedge clk);
        pal_sel <= idx[7:5];
        pix_idx <= idx[4:0];
        // Sample strobe, then the PROM output strobe
        wait_cen_edge();
        wait_cen_edge();
        @(negedge clk);
        check_value("colour_lookup", "red", prom_copy[idx], red);
        check_value("colour_lookup", "green", prom_copy[256 + idx], green);
        check_value("colour_lookup", "blue", prom_copy[512 + idx], blue);
    endtask

    task automatic colour_lookup();
        int          i;
        logic [31:0] r;
        for (i = 0; i < 768; i++) begin
            r = next_random();
            @(posedge clk);
            ioctl_addr <= `MIKIE_PROM_START + 22'(i);
            ioctl_dout <= r[23:16];
            ioctl_wr   <= 1'b1;
            prom_copy[i] = r[19:16];
        end
        @(posedge clk);
        ioctl_wr <= 1'b0;
        for (i = 0; i < 16; i++) begin
            r = next_random();
            lookup_and_check((i == 0) ? 8'h00 : (i == 1) ? 8'hff : r[7:0]);
        end
    endtask

    task automatic frame_timing();
        int   line;
        int   strobes;
        int   lhbl_w;
        int   hs_w;
        int   lvbl_lines;
        int   vs_lines;
        logic line_done;
        logic act_d1;
        logic act_d2;
        lvbl_lines = 0;
        vs_lines = 0;
        act_d1 = 1'b1;
        act_d2 = 1'b1;
        // Last pixel of a frame, the next strobe starts a new one
        do @(negedge clk); while (!(pxl_cen && hcnt == `MIKIE_HTOTAL - 1
                                    && vcnt == `MIKIE_VTOTAL - 1));
        for (line = 0; line < `MIKIE_VTOTAL; line++) begin
            strobes = 0;
            lhbl_w = 0;
            hs_w = 0;
            line_done = 1'b0;
            while (!line_done) begin
                @(negedge clk);
                if (pxl_cen) begin
                    strobes++;
                    lhbl_w += LHBL;
                    hs_w += HS;
                    if (hcnt == 0) begin
                        lvbl_lines += LVBL;
                        vs_lines += VS;
                        // V16 toggles every 16 lines
                        check_value("frame_timing", "V16", line[4], V16);
                    end
                    if (!act_d2) begin
                        check_value("frame_timing", "rgb in blanking", 0, {red, green, blue});
                    end
                    act_d2 = act_d1;
                    act_d1 = LHBL && LVBL;
                    line_done = (hcnt == `MIKIE_HTOTAL - 1);
                end
            end
            check_value("frame_timing", "pxl_cen per line", `MIKIE_HTOTAL, strobes);
            check_value("frame_timing", "LHBL width", `MIKIE_HACTIVE, lhbl_w);
            check_value("frame_timing", "HS width", `MIKIE_HS_LEN, hs_w);
        end
        check_value("frame_timing", "LVBL lines", `MIKIE_VACTIVE, lvbl_lines);
        check_value("frame_timing", "VS lines", `MIKIE_VS_LEN, vs_lines);
    endtask

    initial begin
        reset      <= 1'b1;
        ioctl_addr <= '0;
        ioctl_dout <= '0;
        ioctl_wr   <= 1'b0;
        pix_idx    <= '0;
        pal_sel    <= '0;
        rng_state = 32'h21aa28c1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        reset_and_enables();
        scroll_region();
        object_region();
        colour_lookup();
        frame_timing();
        if (UUT.u_check.failures == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display("a concurrent assertion in the bound checker failed");
            abort_run();
        end
    end

endmodule

//--- verif/mikie_board_checker.sv
/*
 * Concurrent checks bound into the board top level
 * Covers the pixel enable pattern and black output while the blanking,
 * delayed like the colour pipeline, is active.
 */
`timescale 1ns/10ps

module mikie_board_checker (
    input logic       clk,
    input logic       reset,
    input logic       pxl_cen,
    input logic       pxl2_cen,
    input logic       lhbl,
    input logic       lvbl,
    input logic [3:0] red,
    input logic [3:0] green,
    input logic [3:0] blue
);

    int   failures = 0;
    logic blank_d1;
    logic blank_d2;

    // Blanking after two pxl_cen stages, as seen at the RGB pins
    always_ff @(posedge clk) begin
        if (reset) begin
            blank_d1 <= 1'b0;
            blank_d2 <= 1'b0;
        end else if (pxl_cen) begin
            blank_d1 <= ~(lhbl & lvbl);
            blank_d2 <= blank_d1;
        end
    end

    cen_nesting: assert property (@(posedge clk) disable iff (reset) pxl_cen |-> pxl2_cen)
        else begin
            $error("pxl_cen high without pxl2_cen");
            failures++;
        end

    cen_spacing: assert property (@(posedge clk) disable iff (reset)
        !(pxl_cen && $past(pxl_cen)))
        else begin
            $error("pxl_cen high on two cycles in a row");
            failures++;
        end

    blank_black: assert property (@(posedge clk) disable iff (reset)
        blank_d2 |-> (red == 4'd0 && green == 4'd0 && blue == 4'd0))
        else begin
            $error("colour output not black during blanking");
            failures++;
        end

endmodule

//--- verilog/mikie_board.sv
/*
 * Board glue top level
 * Ties together the pixel enables, the ROM download path, the raster
 * timer and the colour stage. The renderer and the memory controller
 * connect from outside through hcnt/vcnt, pix_idx and prog.
 */
`timescale 1ns/10ps
`include "mikie_defines.svh"

module mikie_board (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [`MIKIE_ADDR_W-1:0] ioctl_addr,
    input  logic [7:0]               ioctl_dout,
    input  logic                     ioctl_wr,
    input  logic [4:0]               pix_idx,
    input  logic [2:0]               pal_sel,
    output mikie_pkg::dl_write_t     prog,
    output logic                     pxl_cen,
    output logic                     pxl2_cen,
    output logic [`MIKIE_CNT_W-1:0]  hcnt,
    output logic [`MIKIE_CNT_W-1:0]  vcnt,
    output logic                     HS,
    output logic                     VS,
    output logic                     LHBL,
    output logic                     LVBL,
    output logic                     V16,
    output logic [3:0]               red,
    output logic [3:0]               green,
    output logic [3:0]               blue
);

    mikie_pkg::video_sync_t sync;
    logic                   prom_we;
    logic [9:0]             prom_addr;
    logic [3:0]             prom_data;

    mikie_clocks u_clocks (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .pxl2_cen  ( pxl2_cen  ),
        .pxl_cen   ( pxl_cen   )
    );

    mikie_rom_loader u_loader (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .ioctl_addr ( ioctl_addr ),
        .ioctl_dout ( ioctl_dout ),
        .ioctl_wr   ( ioctl_wr   ),
        .prog       ( prog       ),
        .prom_we    ( prom_we    ),
        .prom_addr  ( prom_addr  ),
        .prom_data  ( prom_data  )
    );

    mikie_vtimer u_vtimer (
        .clk      ( clk      ),
        .reset    ( reset    ),
        .pxl_cen  ( pxl_cen  ),
        .sync     ( sync     ),
        .hcnt     ( hcnt     ),
        .vcnt     ( vcnt     )
    );

    mikie_colmix u_colmix (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .pxl_cen   ( pxl_cen   ),
        .sync      ( sync      ),
        .pix_idx   ( pix_idx   ),
        .pal_sel   ( pal_sel   ),
        .prom_we   ( prom_we   ),
        .prom_addr ( prom_addr ),
        .prom_data ( prom_data ),
        .red       ( red       ),
        .green     ( green     ),
        .blue      ( blue      )
    );

    // Sync levels out to the video connector
    assign HS   = sync.hs;
    assign VS   = sync.vs;
    assign LHBL = sync.lhbl;
    assign LVBL = sync.lvbl;
    assign V16  = sync.v16;

endmodule

//--- verilog/mikie_colmix.sv
/*
 * Colour output stage
 * Three 256x4 colour PROMs, loaded from the download stream, turn the
 * renderer's pixel index and the palette bank into 4-bit RGB. Two
 * pxl_cen stages of latency, with blanking delayed alongside.
 */
`timescale 1ns/10ps

module mikie_colmix (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   pxl_cen,
    input  mikie_pkg::video_sync_t sync,
    input  logic [4:0]             pix_idx,
    input  logic [2:0]             pal_sel,
    input  logic                   prom_we,
    input  logic [9:0]             prom_addr,
    input  logic [3:0]             prom_data,
    output logic [3:0]             red,
    output logic [3:0]             green,
    output logic [3:0]             blue
);

    logic [3:0] red_rom   [0:255];
    logic [3:0] green_rom [0:255];
    logic [3:0] blue_rom  [0:255];

    logic [7:0] lut_addr;
    logic       blank_s1;

    // PROM load, bits 9:8 pick the colour
    always_ff @(posedge clk) begin
        if (prom_we) begin
            case (prom_addr[9:8])
                2'd0:    red_rom[prom_addr[7:0]]   <= prom_data;
                2'd1:    green_rom[prom_addr[7:0]] <= prom_data;
                2'd2:    blue_rom[prom_addr[7:0]]  <= prom_data;
                default: ;
            endcase
        end
    end

    // First stage samples the index
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            lut_addr <= {pal_sel, pix_idx};
        end
    end

    // Blanking follows the pixel through both stages
    always_ff @(posedge clk) begin
        if (reset) begin
            blank_s1 <= 1'b0;
        end else if (pxl_cen) begin
            blank_s1 <= ~(sync.lhbl & sync.lvbl);
        end
    end

    // Second stage looks up the PROMs
    always_ff @(posedge clk) begin
        if (reset) begin
            red   <= 4'd0;
            green <= 4'd0;
            blue  <= 4'd0;
        end else if (pxl_cen) begin
            red   <= blank_s1 ? 4'd0 : red_rom[lut_addr];
            green <= blank_s1 ? 4'd0 : green_rom[lut_addr];
            blue  <= blank_s1 ? 4'd0 : blue_rom[lut_addr];
        end
    end

endmodule

//--- verilog/mikie_vtimer.sv
/*
 * Video raster timing
 * Horizontal and vertical counters stepped by pxl_cen, decoded into
 * sync and blanking levels. The counts are also exported so that a
 * tile and sprite renderer can follow the beam.
 */
`timescale 1ns/10ps
`include "mikie_defines.svh"

module mikie_vtimer (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    pxl_cen,
    output mikie_pkg::video_sync_t  sync,
    output logic [`MIKIE_CNT_W-1:0] hcnt,
    output logic [`MIKIE_CNT_W-1:0] vcnt
);

    localparam logic [`MIKIE_CNT_W-1:0] H_LAST   = `MIKIE_HTOTAL - 1;
    localparam logic [`MIKIE_CNT_W-1:0] V_LAST   = `MIKIE_VTOTAL - 1;
    localparam logic [`MIKIE_CNT_W-1:0] H_ACTIVE = `MIKIE_HACTIVE;
    localparam logic [`MIKIE_CNT_W-1:0] V_ACTIVE = `MIKIE_VACTIVE;
    localparam logic [`MIKIE_CNT_W-1:0] HS_ON    = `MIKIE_HS_START;
    localparam logic [`MIKIE_CNT_W-1:0] HS_OFF   = `MIKIE_HS_START + `MIKIE_HS_LEN;
    localparam logic [`MIKIE_CNT_W-1:0] VS_ON    = `MIKIE_VS_START;
    localparam logic [`MIKIE_CNT_W-1:0] VS_OFF   = `MIKIE_VS_START + `MIKIE_VS_LEN;

    logic h_wrap;

    assign h_wrap = (hcnt == H_LAST);

    // Pixel counter
    always_ff @(posedge clk) begin
        if (reset) begin
            hcnt <= '0;
        end else if (pxl_cen) begin
            hcnt <= h_wrap ? '0 : hcnt + 1'b1;
        end
    end

    // Line counter, steps once per line
    always_ff @(posedge clk) begin
        if (reset) begin
            vcnt <= '0;
        end else if (pxl_cen && h_wrap) begin
            vcnt <= (vcnt == V_LAST) ? '0 : vcnt + 1'b1;
        end
    end

    // Decoded straight from the counters so the windows line up exactly
    always_comb begin
        sync.hs   = (hcnt >= HS_ON) && (hcnt < HS_OFF);
        sync.vs   = (vcnt >= VS_ON) && (vcnt < VS_OFF);
        sync.lhbl = (hcnt < H_ACTIVE);
        sync.lvbl = (vcnt < V_ACTIVE);
        sync.v16  = vcnt[4];
    end

endmodule

//--- verilog/mikie_rom_loader.sv
/*
 * Download side of the board
 * Sorts each ioctl write into a ROM region, swaps scroll ROM nibbles,
 * reorders object ROM addresses and registers the result for the
 * memory side. Colour PROM bytes also go out on the PROM write port.
 */
`timescale 1ns/10ps
`include "mikie_defines.svh"

module mikie_rom_loader (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [`MIKIE_ADDR_W-1:0] ioctl_addr,
    input  logic [7:0]               ioctl_dout,
    input  logic                     ioctl_wr,
    output mikie_pkg::dl_write_t     prog,
    output logic                     prom_we,
    output logic [9:0]               prom_addr,
    output logic [3:0]               prom_data
);

    localparam logic [`MIKIE_ADDR_W-1:0] SCR_START  = `MIKIE_SCR_START;
    localparam logic [`MIKIE_ADDR_W-1:0] OBJ_START  = `MIKIE_OBJ_START;
    localparam logic [`MIKIE_ADDR_W-1:0] PROM_START = `MIKIE_PROM_START;
    // Red, green and blue PROMs of 256 entries each
    localparam logic [`MIKIE_ADDR_W-1:0] PROM_BYTES = 22'd768;

    mikie_pkg::rom_region_e   region;
    logic [`MIKIE_ADDR_W-1:0] post_addr;
    logic [7:0]               post_data;
    logic [`MIKIE_ADDR_W-1:0] prom_off;
    logic                     prom_hit;

    logic [`MIKIE_ADDR_W-1:0] addr_q;
    logic [7:0]               data_q;
    logic                     we_q;

    always_comb begin
        if (ioctl_addr < SCR_START) begin
            region = mikie_pkg::REG_CODE;
        end else if (ioctl_addr < OBJ_START) begin
            region = mikie_pkg::REG_SCR;
        end else if (ioctl_addr < PROM_START) begin
            region = mikie_pkg::REG_OBJ;
        end else begin
            region = mikie_pkg::REG_PROM;
        end
    end

    // Undo the board scrambling
    always_comb begin
        post_addr = ioctl_addr;
        post_data = ioctl_dout;
        if (region == mikie_pkg::REG_SCR) begin
            post_data = {ioctl_dout[3:0], ioctl_dout[7:4]};
        end
        if (region == mikie_pkg::REG_OBJ) begin
            post_addr[15]  = ioctl_addr[0];
            post_addr[14]  = ioctl_addr[15];
            post_addr[0]   = ~ioctl_addr[14];
            post_addr[2:1] = ioctl_addr[5:4] + 2'd1;
            post_addr[6:3] = {ioctl_addr[6], ioctl_addr[3:1]};
        end
    end

    assign prom_off = ioctl_addr - PROM_START;
    assign prom_hit = (region == mikie_pkg::REG_PROM) && (prom_off < PROM_BYTES);

    always_ff @(posedge clk) begin
        if (reset) begin
            we_q    <= 1'b0;
            prom_we <= 1'b0;
        end else begin
            we_q    <= ioctl_wr;
            prom_we <= ioctl_wr & prom_hit;
        end
    end

    // Payload registers, only qualified by the strobes above
    always_ff @(posedge clk) begin
        addr_q    <= post_addr;
        data_q    <= post_data;
        prom_addr <= prom_off[9:0];
        prom_data <= ioctl_dout[3:0];
    end

    assign prog = '{addr: addr_q, data: data_q, we: we_q};

endmodule

//--- verilog/mikie_clocks.sv
/*
 * Pixel clock enables from the 48 MHz system clock
 * pxl2_cen pulses once every 4 clocks and pxl_cen once every 8,
 * always together with a pxl2_cen pulse.
 */
`timescale 1ns/10ps

module mikie_clocks (
    input  logic clk,
    input  logic reset,
    output logic pxl2_cen,
    output logic pxl_cen
);

    logic [2:0] div;

    // Free running divider
    always_ff @(posedge clk) begin
        if (reset) begin
            div <= 3'd0;
        end else begin
            div <= div + 3'd1;
        end
    end

    // Registered pulses, one clk wide
    always_ff @(posedge clk) begin
        if (reset) begin
            pxl2_cen <= 1'b0;
            pxl_cen  <= 1'b0;
        end else begin
            pxl2_cen <= (div[1:0] == 2'd3);
            // Every second pxl2_cen
            pxl_cen  <= (div == 3'd7);
        end
    end

endmodule

//--- verilog/mikie_pkg.sv
/*
 * Shared types of the board glue logic
 * The download region classes, one download write as seen by the
 * memory side, and the bundle of sync and blanking levels.
 */
`include "mikie_defines.svh"

package mikie_pkg;

    // Which part of the ROM set a download byte belongs to
    typedef enum logic [1:0] {
        REG_CODE = 2'd0,
        REG_SCR  = 2'd1,
        REG_OBJ  = 2'd2,
        REG_PROM = 2'd3
    } rom_region_e;

    // One write toward the memory side
    typedef struct packed {
        logic [`MIKIE_ADDR_W-1:0] addr;
        logic [7:0]               data;
        logic                     we;
    } dl_write_t;

    // Video sync and blanking, all levels
    typedef struct packed {
        logic hs;
        logic vs;
        logic lhbl;   // high on active pixels of a line
        logic lvbl;   // high on active lines of a frame
        logic v16;
    } video_sync_t;

endpackage

//--- include/mikie_defines.svh
/*
 * Board constants for the arcade core glue logic
 * Holds the ROM download map and the video raster geometry.
 * Include this file wherever a region boundary or a raster size is needed.
 */
`ifndef MIKIE_DEFINES_SVH
`define MIKIE_DEFINES_SVH

// Download address bus
`define MIKIE_ADDR_W      22

// Byte start of each ROM region in the download stream
`define MIKIE_SCR_START   22'h01_0000
`define MIKIE_OBJ_START   22'h01_8000
`define MIKIE_PROM_START  22'h03_8000

// Horizontal geometry in pixels
`define MIKIE_HTOTAL      384
`define MIKIE_HACTIVE     256
`define MIKIE_HS_START    288
`define MIKIE_HS_LEN      32

// Vertical geometry in lines
`define MIKIE_VTOTAL      264
`define MIKIE_VACTIVE     224
`define MIKIE_VS_START    240
`define MIKIE_VS_LEN      8

// Raster counter width
`define MIKIE_CNT_W       9

`endif
